//--- design/mem_test_pkg.sv
// Memory test package
// Bus widths, command codes, host register map and status field layout
// shared by the register file, the sequencer and the Avalon master stage
package mem_test_pkg;

  // Avalon word address, low data lane and response code
  typedef logic [25:0] avl_addr_t;
  typedef logic [63:0] avl_data_t;
  typedef logic [1:0]  avl_resp_t;

  // Host register port
  typedef logic [3:0]  csr_addr_t;
  typedef logic [63:0] csr_data_t;

  // Mismatch count of the address test, saturates at all ones
  typedef logic [4:0]  err_count_t;

  // CMD_NONE also tags the completion of an address test
  typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_WRITE = 2'd1,
    CMD_READ  = 2'd2
  } mem_cmd_t;

  // ********************************************************************
  // Register map
  // ********************************************************************
  localparam csr_addr_t CSR_SCRATCH   = 4'd0;
  localparam csr_addr_t CSR_MEM_ADDR  = 4'd1;
  localparam csr_addr_t CSR_MEM_WDATA = 4'd2;
  localparam csr_addr_t CSR_MEM_CTRL  = 4'd3;
  localparam csr_addr_t CSR_MEM_RDATA = 4'd4;
  localparam csr_addr_t CSR_STATUS    = 4'd5;

  // CTRL bits, all self-clearing except bank
  localparam int CTRL_WR_BIT    = 0;
  localparam int CTRL_RD_BIT    = 1;
  localparam int CTRL_ATEST_BIT = 2;
  localparam int CTRL_BANK_BIT  = 3;

  // STATUS layout, low to high
  localparam int ST_READY_BIT = 0;
  localparam int ST_DONE_LSB  = 1;
  localparam int ST_RESP_LSB  = 3;
  localparam int ST_ATEST_BIT = 5;
  localparam int ST_ERR_LSB   = 6;

  // Address test length in words
  localparam int ADDR_TEST_WORDS = 16;

  // Avalon responses and the low-lane byte enable
  localparam avl_resp_t   AVL_RESP_OKAY    = 2'd0;
  localparam avl_resp_t   AVL_RESP_SLVERR  = 2'd2;
  localparam logic [63:0] AVL_BYTEEN_LOW64 = 64'h0000_0000_0000_00FF;

endpackage

//--- design/mem_csr.sv
// Memory test register file
// Serves the host register port with a four-phase req/ack handshake,
// holds scratch, address, write data and bank select, launches one
// command per CTRL write and captures the result fields for STATUS
`timescale 1ns/1ps

module mem_csr (
  input  logic                     Clk_400,
  input  logic                     reset,
  // Host register port
  input  logic                     mmio_req,
  input  logic                     mmio_wr,
  input  mem_test_pkg::csr_addr_t  mmio_addr,
  input  mem_test_pkg::csr_data_t  mmio_wdata,
  output logic                     mmio_ack,
  output mem_test_pkg::csr_data_t  mmio_rdata,
  // Results from the sequencer
  input  logic                     done,
  input  mem_test_pkg::mem_cmd_t   done_kind,
  input  mem_test_pkg::avl_data_t  done_rdata,
  input  mem_test_pkg::avl_resp_t  done_resp,
  input  mem_test_pkg::err_count_t done_err,
  // Command launch
  output logic                     start,
  output mem_test_pkg::mem_cmd_t   start_op,
  output logic                     start_atest,
  output mem_test_pkg::avl_addr_t  mem_addr,
  output mem_test_pkg::avl_data_t  mem_wdata,
  output logic                     mem_bank_select
);
  import mem_test_pkg::*;

  logic       accept;
  logic       wr_fire;
  logic       rd_fire;
  logic [2:0] ctrl_ops;
  logic       ctrl_onehot;
  csr_data_t  scratch;
  avl_data_t  rdata_q;
  avl_resp_t  resp_q;
  err_count_t err_q;
  logic       ready;
  logic [1:0] rdwr_done;
  logic       atest_done;
  csr_data_t  status;
  csr_data_t  rd_mux;

  // ********************************************************************
  // Four-phase handshake
  // ********************************************************************
  // New request is taken on the edge that raises ack
  assign accept  = mmio_req && !mmio_ack;
  assign wr_fire = accept && mmio_wr;
  assign rd_fire = accept && !mmio_wr;

  always_ff @(posedge Clk_400) begin
    if (reset) begin
      mmio_ack <= 1'b0;
    end else if (accept) begin
      mmio_ack <= 1'b1;
    end else if (!mmio_req) begin
      mmio_ack <= 1'b0;
    end
  end

  // Read data is captured with ack and held until the next read
  always_ff @(posedge Clk_400) begin
    if (rd_fire) begin
      mmio_rdata <= rd_mux;
    end
  end

  // Status word, unused upper bits read zero
  always_comb begin
    status = '0;
    status[ST_READY_BIT] = ready;
    status[ST_DONE_LSB +: 2] = rdwr_done;
    status[ST_RESP_LSB +: $bits(avl_resp_t)] = resp_q;
    status[ST_ATEST_BIT] = atest_done;
    status[ST_ERR_LSB +: $bits(err_count_t)] = err_q;
  end

  always_comb begin
    case (mmio_addr)
      CSR_SCRATCH:   rd_mux = scratch;
      CSR_MEM_ADDR:  rd_mux = csr_data_t'(mem_addr);
      CSR_MEM_WDATA: rd_mux = mem_wdata;
      CSR_MEM_CTRL:  rd_mux = csr_data_t'(mem_bank_select) << CTRL_BANK_BIT;
      CSR_MEM_RDATA: rd_mux = rdata_q;
      CSR_STATUS:    rd_mux = status;
      default:       rd_mux = '0;
    endcase
  end

  // ********************************************************************
  // Command launch and result capture
  // ********************************************************************
  assign ctrl_ops = {mmio_wdata[CTRL_ATEST_BIT], mmio_wdata[CTRL_RD_BIT],
                     mmio_wdata[CTRL_WR_BIT]};
  // Exactly one operation bit must be set to launch
  assign ctrl_onehot = $onehot(ctrl_ops);

  // Operand registers
  always_ff @(posedge Clk_400) begin
    if (wr_fire && mmio_addr == CSR_MEM_ADDR) begin
      mem_addr <= mmio_wdata[$bits(avl_addr_t)-1:0];
    end
    if (wr_fire && mmio_addr == CSR_MEM_WDATA) begin
      mem_wdata <= mmio_wdata;
    end
    // Writes return no data
    if (done && done_kind != CMD_WRITE) begin
      rdata_q <= done_rdata;
    end
  end

  always_ff @(posedge Clk_400) begin
    if (reset) begin
      scratch         <= '0;
      mem_bank_select <= 1'b0;
      ready           <= 1'b1;
      rdwr_done       <= '0;
      atest_done      <= 1'b0;
      resp_q          <= AVL_RESP_OKAY;
      err_q           <= '0;
      start           <= 1'b0;
      start_op        <= CMD_NONE;
      start_atest     <= 1'b0;
    end else begin
      // Start is a single-cycle pulse
      start <= 1'b0;
      if (wr_fire && mmio_addr == CSR_SCRATCH) begin
        scratch <= mmio_wdata;
      end
      if (wr_fire && mmio_addr == CSR_MEM_CTRL) begin
        // Bank is sticky and follows every CTRL write
        mem_bank_select <= mmio_wdata[CTRL_BANK_BIT];
        if (ready && ctrl_onehot) begin
          start       <= 1'b1;
          start_atest <= mmio_wdata[CTRL_ATEST_BIT];
          start_op    <= mmio_wdata[CTRL_WR_BIT] ? CMD_WRITE :
                         mmio_wdata[CTRL_RD_BIT] ? CMD_READ : CMD_NONE;
          ready       <= 1'b0;
          rdwr_done   <= '0;
          atest_done  <= 1'b0;
        end
      end
      if (done) begin
        ready  <= 1'b1;
        resp_q <= done_resp;
        case (done_kind)
          CMD_WRITE: rdwr_done[0] <= 1'b1;
          CMD_READ:  rdwr_done[1] <= 1'b1;
          default: begin
            // Address test finished
            atest_done <= 1'b1;
            err_q      <= done_err;
          end
        endcase
      end
    end
  end

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge Clk_400) disable iff (reset)
    $rose(mmio_ack) |-> $past(mmio_req));

  // Launch consumes ready and only happens from the ready state
  start_when_ready: assert property (@(posedge Clk_400) disable iff (reset)
    start |-> $past(ready) && !ready);

endmodule

//--- design/mem_fsm.sv
// Memory transaction sequencer
// Runs single reads and writes, or the address test that writes each of
// 16 words with its own address, reads them back and counts mismatches.
// One command in flight, the next one waits for cmd_done
`timescale 1ns/1ps

module mem_fsm (
  input  logic                     Clk_400,
  input  logic                     reset,
  // Launch from the register file
  input  logic                     start,
  input  mem_test_pkg::mem_cmd_t   start_op,
  input  logic                     start_atest,
  input  mem_test_pkg::avl_addr_t  mem_addr,
  input  mem_test_pkg::avl_data_t  mem_wdata,
  // Command path to the Avalon stage
  input  logic                     cmd_done,
  input  mem_test_pkg::avl_data_t  cmd_rdata,
  input  mem_test_pkg::avl_resp_t  cmd_resp,
  output logic                     cmd_valid,
  output mem_test_pkg::mem_cmd_t   cmd,
  output mem_test_pkg::avl_addr_t  cmd_addr,
  output mem_test_pkg::avl_data_t  cmd_wdata,
  // Results
  output logic                     done,
  output mem_test_pkg::mem_cmd_t   done_kind,
  output mem_test_pkg::avl_data_t  done_rdata,
  output mem_test_pkg::avl_resp_t  done_resp,
  output mem_test_pkg::err_count_t done_err
);
  import mem_test_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ISSUE,
    WAIT,
    TEST_WR,
    TEST_RD,
    FINISH
  } state_t;

  state_t                             state;
  mem_cmd_t                           op_q;
  logic                               atest_q;
  logic                               rd_phase;
  logic [$clog2(ADDR_TEST_WORDS)-1:0] idx;
  avl_addr_t                          base_q;
  avl_data_t                          wdata_q;
  avl_addr_t                          test_addr;
  logic                               last_word;
  logic                               wait_read;

  // Current word of the address test
  assign test_addr = base_q + avl_addr_t'(idx);
  assign last_word = &idx;
  // Outstanding command is a read
  assign wait_read = atest_q ? rd_phase : (op_q == CMD_READ);

  // Address test completion is tagged CMD_NONE
  assign done      = (state == FINISH);
  assign done_kind = atest_q ? CMD_NONE : op_q;

  // ********************************************************************
  // Command outputs, one cycle per issue state
  // ********************************************************************
  always_comb begin
    cmd_valid = 1'b0;
    cmd       = CMD_NONE;
    cmd_addr  = base_q;
    cmd_wdata = wdata_q;
    case (state)
      ISSUE: begin
        cmd_valid = 1'b1;
        cmd       = op_q;
      end
      TEST_WR: begin
        // Each word holds its own address
        cmd_valid = 1'b1;
        cmd       = CMD_WRITE;
        cmd_addr  = test_addr;
        cmd_wdata = avl_data_t'(test_addr);
      end
      TEST_RD: begin
        cmd_valid = 1'b1;
        cmd       = CMD_READ;
        cmd_addr  = test_addr;
      end
      default: begin
        cmd_valid = 1'b0;
      end
    endcase
  end

  // ********************************************************************
  // State sequencing
  // ********************************************************************
  always_ff @(posedge Clk_400) begin
    if (reset) begin
      state    <= IDLE;
      atest_q  <= 1'b0;
      rd_phase <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            atest_q  <= start_atest;
            rd_phase <= 1'b0;
            state    <= start_atest ? TEST_WR : ISSUE;
          end
        end
        ISSUE, TEST_WR, TEST_RD: begin
          state <= WAIT;
        end
        WAIT: begin
          if (cmd_done) begin
            if (!atest_q) begin
              state <= FINISH;
            end else if (!last_word) begin
              state <= rd_phase ? TEST_RD : TEST_WR;
            end else if (!rd_phase) begin
              // Write pass done, read back from the base
              rd_phase <= 1'b1;
              state    <= TEST_RD;
            end else begin
              state <= FINISH;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Operands, word index and result fields
  always_ff @(posedge Clk_400) begin
    if (state == IDLE && start) begin
      op_q    <= start_op;
      base_q  <= mem_addr;
      wdata_q <= mem_wdata;
      idx     <= '0;
      if (start_atest) begin
        done_err <= '0;
      end
    end
    if (state == WAIT && cmd_done) begin
      done_resp <= cmd_resp;
      // Index wraps to zero between write and read passes
      if (atest_q) begin
        idx <= idx + 1'b1;
      end
      if (wait_read) begin
        done_rdata <= cmd_rdata;
        // Saturating mismatch count
        if (atest_q && cmd_rdata != avl_data_t'(test_addr) && !(&done_err)) begin
          done_err <= done_err + 1'b1;
        end
      end
    end
  end

  // A command only follows a launch or the completion of the previous one
  issue_after_trigger: assert property (@(posedge Clk_400) disable iff (reset)
    cmd_valid |-> $past(start) || $past(cmd_done));

  // Single outstanding command
  one_in_flight: assert property (@(posedge Clk_400) disable iff (reset)
    cmd_valid |=> !cmd_valid until cmd_done);

endmodule

//--- design/avl_master_port.sv
// Avalon-MM master stage
// Registers the command one cycle after cmd_valid, holds it through
// waitrequest and returns read data and response as one cmd_done pulse
`timescale 1ns/1ps

module avl_master_port (
  input  logic                    Clk_400,
  input  logic                    reset,
  // Command from the sequencer
  input  logic                    cmd_valid,
  input  mem_test_pkg::mem_cmd_t  cmd,
  input  mem_test_pkg::avl_addr_t cmd_addr,
  input  mem_test_pkg::avl_data_t cmd_wdata,
  // Avalon slave returns
  input  logic                    avs_waitrequest,
  input  mem_test_pkg::avl_data_t avs_readdata,
  input  logic                    avs_readdatavalid,
  input  logic                    avs_writeresponsevalid,
  input  mem_test_pkg::avl_resp_t avs_response,
  // Avalon command
  output logic                    avs_read,
  output logic                    avs_write,
  output mem_test_pkg::avl_addr_t avs_address,
  output mem_test_pkg::avl_data_t avs_writedata_low,
  // Completion to the sequencer
  output logic                    cmd_done,
  output mem_test_pkg::avl_data_t cmd_rdata,
  output mem_test_pkg::avl_resp_t cmd_resp
);
  import mem_test_pkg::*;

  // ********************************************************************
  // Command register
  // ********************************************************************
  always_ff @(posedge Clk_400) begin
    if (reset) begin
      avs_read  <= 1'b0;
      avs_write <= 1'b0;
    end else if (cmd_valid) begin
      avs_read  <= (cmd == CMD_READ);
      avs_write <= (cmd == CMD_WRITE);
    end else if (!avs_waitrequest) begin
      // Accepted on this edge, drop next cycle
      avs_read  <= 1'b0;
      avs_write <= 1'b0;
    end
  end

  // Address and data only load with a new command
  always_ff @(posedge Clk_400) begin
    if (cmd_valid) begin
      avs_address       <= cmd_addr;
      avs_writedata_low <= cmd_wdata;
    end
  end

  // ********************************************************************
  // Return register
  // ********************************************************************
  always_ff @(posedge Clk_400) begin
    if (reset) begin
      cmd_done <= 1'b0;
    end else begin
      cmd_done <= avs_readdatavalid || avs_writeresponsevalid;
    end
  end

  always_ff @(posedge Clk_400) begin
    if (avs_readdatavalid) begin
      cmd_rdata <= avs_readdata;
    end
    if (avs_readdatavalid || avs_writeresponsevalid) begin
      cmd_resp <= avs_response;
    end
  end

  rd_wr_exclusive: assert property (@(posedge Clk_400) disable iff (reset)
    !(avs_read && avs_write));

  // Address must not move while the slave stalls
  addr_held: assert property (@(posedge Clk_400) disable iff (reset)
    (avs_read || avs_write) && avs_waitrequest |=> $stable(avs_address));

endmodule

//--- design/hello_mem_afu.sv
// Hello memory AFU top level
// Host register file, transaction sequencer and Avalon master stage.
// Only the low 64 data bits are used, the rest of the bus is tied off
`timescale 1ns/1ps

module hello_mem_afu (
  input  logic                     Clk_400,
  input  logic                     reset,
  // Host register port
  input  logic                     mmio_req,
  input  logic                     mmio_wr,
  input  mem_test_pkg::csr_addr_t  mmio_addr,
  input  mem_test_pkg::csr_data_t  mmio_wdata,
  output logic                     mmio_ack,
  output mem_test_pkg::csr_data_t  mmio_rdata,
  // Avalon-MM master
  output logic [511:0]             avs_writedata,
  input  mem_test_pkg::avl_data_t  avs_readdata,
  output mem_test_pkg::avl_addr_t  avs_address,
  input  logic                     avs_waitrequest,
  output logic                     avs_write,
  output logic                     avs_read,
  output logic [63:0]              avs_byteenable,
  output logic [11:0]              avs_burstcount,
  input  logic                     avs_readdatavalid,
  input  logic                     avs_writeresponsevalid,
  input  mem_test_pkg::avl_resp_t  avs_response,
  output logic                     mem_bank_select
);
  import mem_test_pkg::*;

  // Launch path
  logic       start;
  mem_cmd_t   start_op;
  logic       start_atest;
  avl_addr_t  mem_addr;
  avl_data_t  mem_wdata;
  // Result path
  logic       done;
  mem_cmd_t   done_kind;
  avl_data_t  done_rdata;
  avl_resp_t  done_resp;
  err_count_t done_err;
  // Command path
  logic       cmd_valid;
  mem_cmd_t   cmd;
  avl_addr_t  cmd_addr;
  avl_data_t  cmd_wdata;
  logic       cmd_done;
  avl_data_t  cmd_rdata;
  avl_resp_t  cmd_resp;
  avl_data_t  writedata_low;

  // Single beats on the low lane only
  assign avs_writedata  = {448'd0, writedata_low};
  assign avs_byteenable = AVL_BYTEEN_LOW64;
  assign avs_burstcount = 12'd1;

  mem_csr csr0 (
    .Clk_400         (Clk_400),
    .reset           (reset),
    .mmio_req        (mmio_req),
    .mmio_wr         (mmio_wr),
    .mmio_addr       (mmio_addr),
    .mmio_wdata      (mmio_wdata),
    .mmio_ack        (mmio_ack),
    .mmio_rdata      (mmio_rdata),
    .done            (done),
    .done_kind       (done_kind),
    .done_rdata      (done_rdata),
    .done_resp       (done_resp),
    .done_err        (done_err),
    .start           (start),
    .start_op        (start_op),
    .start_atest     (start_atest),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_bank_select (mem_bank_select)
  );

  mem_fsm fsm0 (
    .Clk_400     (Clk_400),
    .reset       (reset),
    .start       (start),
    .start_op    (start_op),
    .start_atest (start_atest),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .cmd_done    (cmd_done),
    .cmd_rdata   (cmd_rdata),
    .cmd_resp    (cmd_resp),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_addr    (cmd_addr),
    .cmd_wdata   (cmd_wdata),
    .done        (done),
    .done_kind   (done_kind),
    .done_rdata  (done_rdata),
    .done_resp   (done_resp),
    .done_err    (done_err)
  );

  avl_master_port avl0 (
    .Clk_400                (Clk_400),
    .reset                  (reset),
    .cmd_valid              (cmd_valid),
    .cmd                    (cmd),
    .cmd_addr               (cmd_addr),
    .cmd_wdata              (cmd_wdata),
    .avs_waitrequest        (avs_waitrequest),
    .avs_readdata           (avs_readdata),
    .avs_readdatavalid      (avs_readdatavalid),
    .avs_writeresponsevalid (avs_writeresponsevalid),
    .avs_response           (avs_response),
    .avs_read               (avs_read),
    .avs_write              (avs_write),
    .avs_address            (avs_address),
    .avs_writedata_low      (writedata_low),
    .cmd_done               (cmd_done),
    .cmd_rdata              (cmd_rdata),
    .cmd_resp               (cmd_resp)
  );

endmodule

//--- test/avl_mem_model.sv
// Avalon-MM slave model
// Word memory behind a random waitrequest, one accepted command at a time.
// Reads answer after 1 to 4 cycles, writes after one cycle, and addresses
// past the end of the memory give SLVERR with zero read data
`timescale 1ns/1ps

module avl_mem_model #(
  parameter int MODEL_DEPTH = 1024
) (
  input  logic                    Clk_400,
  input  logic                    reset,
  // Command from the master
  input  logic                    avs_read,
  input  logic                    avs_write,
  input  mem_test_pkg::avl_addr_t avs_address,
  input  logic [511:0]            avs_writedata,
  // Slave returns
  output logic                    avs_waitrequest,
  output mem_test_pkg::avl_data_t avs_readdata,
  output logic                    avs_readdatavalid,
  output logic                    avs_writeresponsevalid,
  output mem_test_pkg::avl_resp_t avs_response
);
  import mem_test_pkg::*;

  avl_data_t mem [MODEL_DEPTH];
  int        wait_cnt;
  logic      pend_read;
  avl_data_t pend_data;
  avl_resp_t pend_resp;
  logic      in_range;

  assign in_range = (avs_address < MODEL_DEPTH);

  initial begin
    // Fill word carries its own address in both halves
    for (int i = 0; i < MODEL_DEPTH; i++) begin
      mem[i] = {16'hA5C3, 16'(i), 32'(~i)};
    end
    avs_waitrequest        = 1'b1;
    avs_readdata           = '0;
    avs_readdatavalid      = 1'b0;
    avs_writeresponsevalid = 1'b0;
    avs_response           = AVL_RESP_OKAY;
    wait_cnt               = 0;
    pend_read              = 1'b0;
    pend_data              = '0;
    pend_resp              = AVL_RESP_OKAY;
  end

  // ********************************************************************
  // Accept, count down, answer
  // ********************************************************************
  // Outputs move 1 ns after the edge, state updates on the edge
  always @(posedge Clk_400) begin
    if (reset) begin
      avs_waitrequest        <= #1 1'b1;
      avs_readdatavalid      <= #1 1'b0;
      avs_writeresponsevalid <= #1 1'b0;
      wait_cnt               <= 0;
    end else begin
      // Stall about one cycle in three
      avs_waitrequest        <= #1 ($urandom_range(2) == 0);
      avs_readdatavalid      <= #1 (wait_cnt == 1) && pend_read;
      avs_writeresponsevalid <= #1 (wait_cnt == 1) && !pend_read;
      if (wait_cnt == 1) begin
        avs_readdata <= #1 pend_data;
        avs_response <= #1 pend_resp;
      end
      if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end
      // Command is taken on an edge without waitrequest
      if ((avs_read || avs_write) && !avs_waitrequest) begin
        pend_read <= avs_read;
        pend_resp <= in_range ? AVL_RESP_OKAY : AVL_RESP_SLVERR;
        pend_data <= (avs_read && in_range) ? mem[avs_address] : '0;
        wait_cnt  <= avs_read ? 1 + int'($urandom_range(3)) : 1;
        // Out of range writes are dropped
        if (avs_write && in_range) begin
          mem[avs_address] <= avs_writedata[63:0];
        end
      end
    end
  end

endmodule

//--- test/tb_hello_mem_afu.sv
// Hello memory AFU testbench
// Drives the host register port through scratch, single transfers, bank
// select and address tests against an Avalon memory model, and checks
// results against a shadow memory and a reference mismatch count
`timescale 1ns/1ps

module tb_hello_mem_afu;
  import mem_test_pkg::*;

  localparam int          MODEL_DEPTH   = 1024;
  localparam int unsigned SEED          = 13433;
  localparam int          ACK_TIMEOUT   = 20;
  localparam int          READY_TIMEOUT = 400;

  logic         Clk_400;
  logic         reset;
  logic         mmio_req;
  logic         mmio_wr;
  csr_addr_t    mmio_addr;
  csr_data_t    mmio_wdata;
  logic         mmio_ack;
  csr_data_t    mmio_rdata;
  logic [511:0] avs_writedata;
  avl_data_t    avs_readdata;
  avl_addr_t    avs_address;
  logic         avs_waitrequest;
  logic         avs_write;
  logic         avs_read;
  logic [63:0]  avs_byteenable;
  logic [11:0]  avs_burstcount;
  logic         avs_readdatavalid;
  logic         avs_writeresponsevalid;
  avl_resp_t    avs_response;
  logic         mem_bank_select;

  // Expected bank and the words written through the DUT
  logic         exp_bank;
  avl_data_t    shadow [int unsigned];
  int           error_count;
  // Avalon commands accepted by the slave
  int           avl_cmds;
  csr_data_t    status;
  csr_data_t    rd_val;
  avl_addr_t    addr;
  avl_data_t    data;

  hello_mem_afu dut0 (.*);

  avl_mem_model #(.MODEL_DEPTH(MODEL_DEPTH)) mem0 (
    .Clk_400                (Clk_400),
    .reset                  (reset),
    .avs_read               (avs_read),
    .avs_write              (avs_write),
    .avs_address            (avs_address),
    .avs_writedata          (avs_writedata),
    .avs_waitrequest        (avs_waitrequest),
    .avs_readdata           (avs_readdata),
    .avs_readdatavalid      (avs_readdatavalid),
    .avs_writeresponsevalid (avs_writeresponsevalid),
    .avs_response           (avs_response)
  );

  initial begin
    Clk_400 = 1'b0;
    forever #50 Clk_400 = ~Clk_400;
  end

  // ********************************************************************
  // Reference, checks and host tasks
  // ********************************************************************
  // Mismatches of the address test: out of range words read zero
  function automatic int expected_err(input avl_addr_t base);
    avl_addr_t a;
    int        n;
    n = 0;
    for (int i = 0; i < ADDR_TEST_WORDS; i++) begin
      a = avl_addr_t'(base + i);
      if (a >= MODEL_DEPTH && a != 0) n++;
    end
    return (n > 31) ? 31 : n;
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s expected 0x%0h got 0x%0h", $time, what, exp, got);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic apply_reset();
    @(posedge Clk_400);
    #1;
    reset    = 1'b1;
    exp_bank = 1'b0;
    repeat (4) @(posedge Clk_400);
    #1;
    reset = 1'b0;
  endtask

  // One four-phase transfer, read data taken while ack is high
  task automatic mmio_access(input logic wr, input csr_addr_t a, input csr_data_t d,
                             output csr_data_t rd);
    int n;
    @(posedge Clk_400);
    #1;
    mmio_req   = 1'b1;
    mmio_wr    = wr;
    mmio_addr  = a;
    mmio_wdata = d;
    n = 0;
    while (!mmio_ack) begin
      if (n == ACK_TIMEOUT) fail_run("Timeout: mmio_ack never rose");
      n++;
      @(posedge Clk_400);
      #1;
    end
    rd = mmio_rdata;
    // Write took effect on the ack edge
    if (wr && a == CSR_MEM_CTRL) exp_bank = d[CTRL_BANK_BIT];
    mmio_req = 1'b0;
    n = 0;
    while (mmio_ack) begin
      if (n == ACK_TIMEOUT) fail_run("Timeout: mmio_ack never fell");
      n++;
      @(posedge Clk_400);
      #1;
    end
  endtask

  task automatic mmio_write(input csr_addr_t a, input csr_data_t d);
    csr_data_t unused;
    mmio_access(1'b1, a, d, unused);
  endtask

  task automatic mmio_read(input csr_addr_t a, output csr_data_t rd);
    mmio_access(1'b0, a, '0, rd);
  endtask

  // Poll STATUS until ready
  task automatic wait_ready(output csr_data_t st);
    int n;
    n = 0;
    mmio_read(CSR_STATUS, st);
    while (!st[ST_READY_BIT]) begin
      if (n == READY_TIMEOUT) fail_run("Timeout: STATUS ready stayed low");
      n++;
      mmio_read(CSR_STATUS, st);
    end
  endtask

  task automatic run_op(input csr_data_t ctrl, output csr_data_t st);
    mmio_write(CSR_MEM_CTRL, ctrl);
    wait_ready(st);
  endtask

  task automatic check_result(input csr_data_t st, input logic [1:0] done_bits,
                              input avl_resp_t resp);
    check_equal(st[ST_DONE_LSB +: 2], done_bits, "STATUS rdwr_done");
    check_equal(st[ST_RESP_LSB +: 2], resp, "STATUS response");
  endtask

  // Address test with a read launch attempted while busy
  task automatic run_atest(input avl_addr_t base, output csr_data_t st);
    avl_addr_t a;
    csr_data_t busy;
    int        cmds_before;
    mmio_write(CSR_MEM_ADDR, csr_data_t'(base));
    cmds_before = avl_cmds;
    mmio_write(CSR_MEM_CTRL, 64'd1 << CTRL_ATEST_BIT);
    mmio_read(CSR_STATUS, busy);
    check_equal(busy[ST_READY_BIT], 1'b0, "ready during address test");
    mmio_write(CSR_MEM_CTRL, 64'd1 << CTRL_RD_BIT);
    wait_ready(st);
    // Dropped read leaves the read done bit clear
    check_equal(st[ST_ATEST_BIT], 1'b1, "STATUS addr_test_done");
    check_equal(st[ST_DONE_LSB +: 2], 2'b00, "rdwr_done after address test");
    check_equal(st[ST_ERR_LSB +: 5], expected_err(base), "address test err_count");
    // One write and one read per word and nothing else
    check_equal(avl_cmds - cmds_before, 2 * ADDR_TEST_WORDS,
                "Avalon commands of address test");
    for (int i = 0; i < ADDR_TEST_WORDS; i++) begin
      a = avl_addr_t'(base + i);
      if (a < MODEL_DEPTH) shadow[a] = avl_data_t'(a);
    end
  endtask

  // Bank select and tied Avalon fields compared on every falling edge outside reset
  always @(negedge Clk_400) begin
    if (!reset) begin
      check_equal(64'(mem_bank_select), 64'(exp_bank), "mem_bank_select");
      if (avs_read || avs_write) begin
        // Single beat on the low 8 byte lanes
        check_equal(avs_byteenable, 64'h0000_0000_0000_00FF, "avs_byteenable");
        check_equal(64'(avs_burstcount), 64'd1, "avs_burstcount");
        // Slave takes the command on the next rising edge
        if (!avs_waitrequest) avl_cmds++;
      end
      if (avs_write) begin
        check_equal(64'(|avs_writedata[511:64]), 64'd0, "avs_writedata upper lanes");
      end
    end
  end

  // ********************************************************************
  // Test sequence
  // ********************************************************************
  initial begin
    void'($urandom(SEED));
    error_count = 0;
    avl_cmds    = 0;
    exp_bank    = 1'b0;
    reset       = 1'b1;
    mmio_req    = 1'b0;
    mmio_wr     = 1'b0;
    mmio_addr   = '0;
    mmio_wdata  = '0;
    apply_reset();

    // Scratch readback, then cleared by reset
    mmio_write(CSR_SCRATCH, 64'h0123_4567_89AB_CDEF);
    mmio_read(CSR_SCRATCH, rd_val);
    check_equal(rd_val, 64'h0123_4567_89AB_CDEF, "scratch readback");
    apply_reset();
    mmio_read(CSR_SCRATCH, rd_val);
    check_equal(rd_val, '0, "scratch after reset");

    // Single write then read at random in-range addresses
    repeat (4) begin
      addr = avl_addr_t'($urandom_range(MODEL_DEPTH - 1));
      data = {$urandom, $urandom};
      mmio_write(CSR_MEM_ADDR, csr_data_t'(addr));
      mmio_write(CSR_MEM_WDATA, data);
      run_op(64'd1 << CTRL_WR_BIT, status);
      check_result(status, 2'b01, AVL_RESP_OKAY);
      shadow[addr] = data;
      run_op(64'd1 << CTRL_RD_BIT, status);
      check_result(status, 2'b10, AVL_RESP_OKAY);
      mmio_read(CSR_MEM_RDATA, rd_val);
      check_equal(rd_val, shadow[addr], "single read data");
    end

    // Bank bit set, then kept by a launch that carries it
    mmio_write(CSR_MEM_CTRL, 64'd1 << CTRL_BANK_BIT);
    run_op((64'd1 << CTRL_BANK_BIT) | (64'd1 << CTRL_RD_BIT), status);
    check_result(status, 2'b10, AVL_RESP_OKAY);
    mmio_read(CSR_MEM_CTRL, rd_val);
    check_equal(rd_val, 64'd1 << CTRL_BANK_BIT, "CTRL bank readback");
    check_equal(64'(mem_bank_select), 64'd1, "bank after launch");
    mmio_write(CSR_MEM_CTRL, '0);

    // Address test fully inside the model
    addr = avl_addr_t'($urandom_range(MODEL_DEPTH - ADDR_TEST_WORDS));
    run_atest(addr, status);
    check_equal(status[ST_RESP_LSB +: 2], AVL_RESP_OKAY, "address test response");
    for (int i = 0; i < ADDR_TEST_WORDS; i += 5) begin
      mmio_write(CSR_MEM_ADDR, csr_data_t'(avl_addr_t'(addr + i)));
      run_op(64'd1 << CTRL_RD_BIT, status);
      check_result(status, 2'b10, AVL_RESP_OKAY);
      mmio_read(CSR_MEM_RDATA, rd_val);
      check_equal(rd_val, csr_data_t'(avl_addr_t'(addr + i)), "word after address test");
    end

    // Address test running past the end, then a single out of range read
    addr = avl_addr_t'(MODEL_DEPTH - 6);
    run_atest(addr, status);
    check_equal(status[ST_RESP_LSB +: 2], AVL_RESP_SLVERR, "address test response");
    mmio_write(CSR_MEM_ADDR, csr_data_t'(MODEL_DEPTH + 100));
    run_op(64'd1 << CTRL_RD_BIT, status);
    check_result(status, 2'b10, AVL_RESP_SLVERR);
    mmio_read(CSR_MEM_RDATA, rd_val);
    check_equal(rd_val, '0, "out of range read data");

    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hello_mem_afu.f
design/mem_test_pkg.sv
design/mem_csr.sv
design/mem_fsm.sv
design/avl_master_port.sv
design/hello_mem_afu.sv
test/avl_mem_model.sv
test/tb_hello_mem_afu.sv

//--- Bender.yml
package:
  name: hello_mem_afu

sources:
  - design/mem_test_pkg.sv
  - design/mem_csr.sv
  - design/mem_fsm.sv
  - design/avl_master_port.sv
  - design/hello_mem_afu.sv
  - target: test
    files:
      - test/avl_mem_model.sv
      - test/tb_hello_mem_afu.sv
